/* rtl/cache_pkg.sv */
package cache_pkg;

    // *************************************************************************
    // cache geometry
    // *************************************************************************
    localparam int s_offset = 5;                  // byte offset bits within a line.
    localparam int s_index  = 4;                  // set index bits.
    localparam int s_wayidx = 2;                  // way number bits.
    localparam int s_tag    = 23;                 // what is left of a 32-bit address.
    localparam int s_line   = 256;                // bits per line.
    localparam int num_sets = 16;
    localparam int num_ways = 4;
    localparam int s_mask   = 32;                 // one enable per byte of a line.

    typedef logic [31:0]           addr_t;
    typedef logic [s_line-1:0]     line_t;
    typedef logic [s_mask-1:0]     mask_t;
    typedef logic [s_tag-1:0]      tag_t;
    typedef logic [s_index-1:0]    index_t;
    typedef logic [s_wayidx-1:0]   way_t;
    typedef logic [num_ways-2:0]   plru_t;        // bit 0 is the root of the tree.

    // *************************************************************************
    // bundles between the ports, the FSM and the datapath
    // *************************************************************************
    typedef struct packed {
        logic  read;
        logic  write;
        addr_t address;
        mask_t byte_enable;
        line_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  read;
        logic  write;
        addr_t address;
        line_t wdata;
    } pmem_req_t;

    typedef struct packed {
        logic ld_valid;
        logic ld_dirty;
        logic ld_tag;
        logic ld_data;
        logic ld_plru;
        logic dirty_val;
        logic dirty_victim;                       // dirty write goes to the victim way.
        logic data_victim;                        // data write goes to the victim way.
        logic data_from_mem;                      // full line from memory, else CPU bytes.
        logic addr_from_victim;                   // memory address carries the victim tag.
    } dp_ctrl_t;

    typedef struct packed {
        logic hit;
        logic victim_dirty;
    } dp_status_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        compare,
        writeback,
        fill
    } cache_state_t;

endpackage

/* rtl/cache_data_sram.sv */
`timescale 1ns/1ps

module cache_data_sram (
    input  logic              clk,
    input  logic              we,
    input  cache_pkg::mask_t  wmask,
    input  cache_pkg::index_t addr,
    input  cache_pkg::line_t  din,
    output cache_pkg::line_t  dout
);

    cache_pkg::line_t lines [cache_pkg::num_sets];

    // the read happens on the same edge as the write, so a colliding
    // read sees the line as it was before the write.
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < cache_pkg::s_mask; b++) begin
                if (wmask[b]) begin
                    lines[addr][b*8 +: 8] <= din[b*8 +: 8];   // only enabled bytes change.
                end
            end
        end
        dout <= lines[addr];
    end

endmodule

/* rtl/cache_tag_sram.sv */
`timescale 1ns/1ps

module cache_tag_sram (
    input  logic              clk,
    input  logic              we,
    input  cache_pkg::index_t addr,
    input  cache_pkg::tag_t   din,
    output cache_pkg::tag_t   dout
);

    cache_pkg::tag_t tags [cache_pkg::num_sets];

    always_ff @(posedge clk) begin
        if (we) begin
            tags[addr] <= din;                    // whole tag replaced on a fill.
        end
        dout <= tags[addr];                       // registered read of the old value.
    end

endmodule

/* rtl/cache_flag_array.sv */
`timescale 1ns/1ps

module cache_flag_array (
    input  logic              clk,
    input  logic              rst,
    input  logic              we,
    input  cache_pkg::index_t addr,
    input  logic              din,
    output logic              dout
);

    logic [cache_pkg::num_sets-1:0] bits;

    // one flag per set, kept in flops so that reset can clear all of them
    always_ff @(posedge clk) begin
        if (rst) begin
            bits <= '0;
            dout <= 1'b0;
        end else begin
            if (we) begin
                bits[addr] <= din;
            end
            dout <= bits[addr];                   // same timing as the SRAMs.
        end
    end

endmodule

/* rtl/cache_datapath.sv */
`timescale 1ns/1ps

module cache_datapath (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::cpu_req_t   req,
    input  cache_pkg::dp_ctrl_t   ctrl,
    output cache_pkg::dp_status_t status,
    output cache_pkg::line_t      mem_rdata,
    output cache_pkg::addr_t      pmem_address,
    output cache_pkg::line_t      pmem_wdata,
    input  cache_pkg::line_t      pmem_rdata
);

    cache_pkg::tag_t   req_tag;
    cache_pkg::index_t req_index;

    cache_pkg::line_t  data_q [cache_pkg::num_ways];
    cache_pkg::tag_t   tag_q  [cache_pkg::num_ways];
    logic [cache_pkg::num_ways-1:0] valid_q;
    logic [cache_pkg::num_ways-1:0] dirty_q;

    logic [cache_pkg::num_ways-1:0] hit_vec;      // one bit per way, at most one set.
    logic [cache_pkg::num_ways-1:0] victim_oh;
    logic [cache_pkg::num_ways-1:0] data_we;
    logic [cache_pkg::num_ways-1:0] dirty_we;
    cache_pkg::way_t   hit_way;
    cache_pkg::way_t   victim_way;

    cache_pkg::mask_t  wr_mask;
    cache_pkg::line_t  wr_line;

    cache_pkg::plru_t  plru [cache_pkg::num_sets];
    cache_pkg::plru_t  plru_cur;
    cache_pkg::plru_t  plru_next;

    assign req_tag   = req.address[31 -: cache_pkg::s_tag];
    assign req_index = req.address[cache_pkg::s_offset +: cache_pkg::s_index];

    // *************************************************************************
    // per-way storage
    // *************************************************************************
    assign wr_mask   = ctrl.data_from_mem ? '1 : req.byte_enable;
    assign wr_line   = ctrl.data_from_mem ? pmem_rdata : req.wdata;
    assign victim_oh = cache_pkg::num_ways'(1) << victim_way;
    assign data_we   = {cache_pkg::num_ways{ctrl.ld_data}}
                     & (ctrl.data_victim ? victim_oh : hit_vec);
    assign dirty_we  = {cache_pkg::num_ways{ctrl.ld_dirty}}
                     & (ctrl.dirty_victim ? victim_oh : hit_vec);

    for (genvar i = 0; i < cache_pkg::num_ways; i++) begin : g_way
        cache_data_sram u_data (
            .clk   (clk),
            .we    (data_we[i]),
            .wmask (wr_mask),
            .addr  (req_index),
            .din   (wr_line),
            .dout  (data_q[i])
        );

        cache_tag_sram u_tag (
            .clk   (clk),
            .we    (ctrl.ld_tag & victim_oh[i]),   // tags only change on a fill.
            .addr  (req_index),
            .din   (req_tag),
            .dout  (tag_q[i])
        );

        cache_flag_array u_valid (
            .clk   (clk),
            .rst   (rst),
            .we    (ctrl.ld_valid & victim_oh[i]),
            .addr  (req_index),
            .din   (1'b1),
            .dout  (valid_q[i])
        );

        cache_flag_array u_dirty (
            .clk   (clk),
            .rst   (rst),
            .we    (dirty_we[i]),
            .addr  (req_index),
            .din   (ctrl.dirty_val),
            .dout  (dirty_q[i])
        );

        assign hit_vec[i] = valid_q[i] & (tag_q[i] == req_tag);  // a never filled way misses.
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            if (hit_vec[w]) begin
                hit_way = cache_pkg::way_t'(w);
            end
        end
    end

    // *************************************************************************
    // tree PLRU, node 0 is the root, node 1 covers ways 0 and 1, node 2 ways 2 and 3
    // *************************************************************************
    assign plru_cur = plru[req_index];

    // each node stores the direction last taken, the victim walks the other way.
    assign victim_way[1] = ~plru_cur[0];
    assign victim_way[0] = victim_way[1] ? ~plru_cur[2] : ~plru_cur[1];

    always_comb begin
        plru_next    = plru_cur;
        plru_next[0] = hit_way[1];
        if (hit_way[1]) begin
            plru_next[2] = hit_way[0];
        end else begin
            plru_next[1] = hit_way[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < cache_pkg::num_sets; s++) begin
                plru[s] <= '0;
            end
        end else if (ctrl.ld_plru) begin
            plru[req_index] <= plru_next;
        end
    end

    // *************************************************************************
    // outputs
    // *************************************************************************
    assign status.hit          = |hit_vec;
    assign status.victim_dirty = valid_q[victim_way] & dirty_q[victim_way];

    assign mem_rdata    = data_q[hit_way];
    assign pmem_wdata   = data_q[victim_way];  // only the victim is ever written back.
    assign pmem_address = {ctrl.addr_from_victim ? tag_q[victim_way] : req_tag,
                           req_index, {cache_pkg::s_offset{1'b0}}};

    // a tag lives in at most one valid way of a set, as long as fills only follow misses.
    assert property (@(posedge clk) disable iff (rst)
        (req.read || req.write) |-> $onehot0(hit_vec))
        else $error("more than one way hits in set %0d", req_index);

endmodule

/* rtl/cache_control.sv */
`timescale 1ns/1ps

module cache_control (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::cpu_req_t   req,
    input  cache_pkg::dp_status_t status,
    output cache_pkg::dp_ctrl_t   ctrl,
    output logic                  mem_resp,
    output logic                  pmem_read,
    output logic                  pmem_write,
    input  logic                  pmem_resp
);

    cache_pkg::cache_state_t state;
    cache_pkg::cache_state_t state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_pkg::idle;
        end else begin
            state <= state_next;
        end
    end

    // *************************************************************************
    // next state and output decode
    // *************************************************************************
    always_comb begin
        state_next = state;
        ctrl       = '0;
        mem_resp   = 1'b0;
        pmem_read  = 1'b0;
        pmem_write = 1'b0;

        unique case (state)
            cache_pkg::idle: begin
                if (req.read || req.write) begin
                    state_next = cache_pkg::lookup;  // the set index is already at the SRAMs.
                end
            end

            cache_pkg::lookup: begin
                state_next = cache_pkg::compare;     // tag, valid and dirty are read out here.
            end

            cache_pkg::compare: begin
                if (status.hit) begin
                    mem_resp     = 1'b1;
                    ctrl.ld_plru = 1'b1;
                    if (req.write) begin
                        // merge the CPU bytes into the hit line and mark it dirty.
                        ctrl.ld_data   = 1'b1;
                        ctrl.ld_dirty  = 1'b1;
                        ctrl.dirty_val = 1'b1;
                    end
                    state_next = cache_pkg::idle;
                end else if (status.victim_dirty) begin
                    state_next = cache_pkg::writeback;
                end else begin
                    state_next = cache_pkg::fill;   // a clean victim is simply overwritten.
                end
            end

            cache_pkg::writeback: begin
                pmem_write            = 1'b1;
                ctrl.addr_from_victim = 1'b1;       // old line goes back to its own address.
                if (pmem_resp) begin
                    state_next = cache_pkg::fill;
                end
            end

            cache_pkg::fill: begin
                pmem_read = 1'b1;
                if (pmem_resp) begin
                    // the new line replaces the victim and arrives clean.
                    ctrl.ld_data       = 1'b1;
                    ctrl.data_victim   = 1'b1;
                    ctrl.data_from_mem = 1'b1;
                    ctrl.ld_tag        = 1'b1;
                    ctrl.ld_valid      = 1'b1;
                    ctrl.ld_dirty      = 1'b1;
                    ctrl.dirty_victim  = 1'b1;
                    ctrl.dirty_val     = 1'b0;
                    state_next         = cache_pkg::lookup;  // re-read the set, which now hits.
                end
            end

            default: begin
                state_next = cache_pkg::idle;
            end
        endcase
    end

    // *************************************************************************
    // protocol checks
    // *************************************************************************
    assert property (@(posedge clk) disable iff (rst)
        !(pmem_read && pmem_write))
        else $error("pmem_read and pmem_write are both high");

    assert property (@(posedge clk) disable iff (rst)
        mem_resp |-> (state == cache_pkg::compare) && $past(state) == cache_pkg::lookup)
        else $error("mem_resp outside of compare");

    // the CPU keeps its request steady from the sampling edge until mem_resp.
    assert property (@(posedge clk) disable iff (rst)
        (state != cache_pkg::idle) |-> $stable(req))
        else $error("the CPU request changed while it was pending");

endmodule

/* rtl/cache.sv */
`timescale 1ns/1ps

module cache (
    input  logic              clk,
    input  logic              rst,

    input  logic              mem_read,
    input  logic              mem_write,
    input  cache_pkg::addr_t  mem_address,
    input  cache_pkg::mask_t  mem_byte_enable,
    input  cache_pkg::line_t  mem_wdata,
    output cache_pkg::line_t  mem_rdata,
    output logic              mem_resp,

    output logic              pmem_read,
    output logic              pmem_write,
    output cache_pkg::addr_t  pmem_address,
    output cache_pkg::line_t  pmem_wdata,
    input  cache_pkg::line_t  pmem_rdata,
    input  logic              pmem_resp
);

    cache_pkg::cpu_req_t   cpu_req;
    cache_pkg::pmem_req_t  pmem_req;
    cache_pkg::dp_ctrl_t   ctrl;
    cache_pkg::dp_status_t status;

    assign cpu_req = '{
        read:        mem_read,
        write:       mem_write,
        address:     mem_address,
        byte_enable: mem_byte_enable,
        wdata:       mem_wdata
    };

    cache_control u_control (
        .clk        (clk),
        .rst        (rst),
        .req        (cpu_req),
        .status     (status),
        .ctrl       (ctrl),
        .mem_resp   (mem_resp),
        .pmem_read  (pmem_req.read),
        .pmem_write (pmem_req.write),
        .pmem_resp  (pmem_resp)
    );

    cache_datapath u_datapath (
        .clk          (clk),
        .rst          (rst),
        .req          (cpu_req),
        .ctrl         (ctrl),
        .status       (status),
        .mem_rdata    (mem_rdata),
        .pmem_address (pmem_req.address),
        .pmem_wdata   (pmem_req.wdata),
        .pmem_rdata   (pmem_rdata)
    );

    assign pmem_read    = pmem_req.read;
    assign pmem_write   = pmem_req.write;
    assign pmem_address = pmem_req.address;
    assign pmem_wdata   = pmem_req.wdata;

endmodule

/* test/cache_checker.sv */
`timescale 1ns/1ps

module cache_checker (
    input logic             clk,
    input logic             rst,
    input logic             mem_read,
    input logic             mem_write,
    input cache_pkg::addr_t mem_address,
    input cache_pkg::mask_t mem_byte_enable,
    input cache_pkg::line_t mem_wdata,
    input cache_pkg::line_t mem_rdata,
    input logic             mem_resp,
    input logic             pmem_read,
    input logic             pmem_write,
    input cache_pkg::addr_t pmem_address,
    input cache_pkg::line_t pmem_wdata,
    input cache_pkg::line_t pmem_rdata,
    input logic             pmem_resp
);

    typedef struct packed {
        logic             hit;
        logic             writeback;
        cache_pkg::addr_t wb_address;
        cache_pkg::line_t wb_line;
        cache_pkg::addr_t fill_address;
        cache_pkg::line_t rdata;
    } expect_t;

    cache_pkg::line_t golden    [128];            // the memory as the CPU should see it.
    cache_pkg::tag_t  ref_tag   [cache_pkg::num_sets][cache_pkg::num_ways];
    logic             ref_valid [cache_pkg::num_sets][cache_pkg::num_ways];
    logic             ref_dirty [cache_pkg::num_sets][cache_pkg::num_ways];
    cache_pkg::plru_t ref_plru  [cache_pkg::num_sets];

    expect_t expected;
    logic    busy;
    logic    saw_read;
    logic    saw_write;
    int      cycles;                              // edges since the sampling edge.
    int      since_resp;                          // edges since the last pmem_resp.
    int      errors;
    int      errors_at_start;
    int      tests_passed;
    int      tests_failed;

    // every word of the initial image is a scramble of its own byte address.
    function automatic cache_pkg::line_t line_pattern(input cache_pkg::addr_t line_address);
        cache_pkg::line_t line;
        logic [31:0]      word_address;
        for (int w = 0; w < 8; w++) begin
            word_address = {line_address[31:5], 3'(w), 2'b00};
            line[w*32 +: 32] = (word_address * 32'h9e37_79b1) ^ 32'h5bd1_e995;
        end
        return line;
    endfunction

    // *************************************************************************
    // reference cache, updated once per request at its sampling edge
    // *************************************************************************
    function automatic expect_t predict(input logic write, input cache_pkg::addr_t address,
                                        input cache_pkg::mask_t enables,
                                        input cache_pkg::line_t wdata);
        expect_t           e;
        cache_pkg::index_t index;
        cache_pkg::tag_t   tag;
        logic [6:0]        slot;
        int                way;
        int                node;
        index = address[8:5];
        tag   = address[31:9];
        slot  = address[11:5];
        e     = '0;
        way   = -1;
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            if (ref_valid[index][w] && ref_tag[index][w] == tag) begin
                way = w;
            end
        end
        e.hit = (way >= 0);
        if (!e.hit) begin
            node           = ref_plru[index][0] ? 1 : 2;   // go against the root.
            way            = 2 * (node - 1) + (ref_plru[index][node] ? 0 : 1);
            e.writeback    = ref_valid[index][way] && ref_dirty[index][way];
            e.wb_address   = {ref_tag[index][way], index, 5'b0};
            e.wb_line      = golden[e.wb_address[11:5]];
            e.fill_address = {tag, index, 5'b0};
            ref_tag[index][way]   = tag;
            ref_valid[index][way] = 1'b1;
            ref_dirty[index][way] = 1'b0;
        end
        ref_plru[index][0]            = (way >= 2);     // the path records where it went.
        ref_plru[index][1 + way / 2]  = (way % 2 == 1);
        e.rdata = golden[slot];                         // the line before any merge.
        if (write) begin
            for (int b = 0; b < cache_pkg::s_mask; b++) begin
                if (enables[b]) begin
                    golden[slot][b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
            ref_dirty[index][way] = 1'b1;
        end
        return e;
    endfunction

    task automatic compare_value(input string name, input logic [255:0] want,
                                 input logic [255:0] got);
        if (got !== want) begin
            errors++;
            $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, want, got);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic finish_test(input string name);
        int n;
        n = errors - errors_at_start;
        if (n == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, n);
        end
        errors_at_start = errors;
    endtask

    initial begin
        for (int i = 0; i < 128; i++) begin
            golden[i] = line_pattern({20'b0, 7'(i), 5'b0});
        end
        for (int s = 0; s < cache_pkg::num_sets; s++) begin
            ref_plru[s] = '0;
            for (int w = 0; w < cache_pkg::num_ways; w++) begin
                ref_tag[s][w]   = '0;
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
            end
        end
        busy            = 1'b0;
        errors          = 0;
        errors_at_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;
    end

    // *************************************************************************
    // compare process, sampling the values that stood before each rising edge
    // *************************************************************************
    always @(posedge clk) begin
        if (rst) begin
            busy = 1'b0;
        end else if (!busy) begin
            if (mem_read || mem_write) begin
                busy      = 1'b1;
                cycles    = 0;
                saw_read  = 1'b0;
                saw_write = 1'b0;
                expected  = predict(mem_write, mem_address, mem_byte_enable, mem_wdata);
            end else if (mem_resp || pmem_read || pmem_write) begin
                report_failure("the cache is active with no request pending");
            end
        end else begin
            cycles++;
            since_resp++;
            if (pmem_write && pmem_resp) begin
                saw_write  = 1'b1;
                since_resp = 0;
                if (!expected.writeback) begin
                    report_failure("a write-back that the reference model did not expect");
                end else begin
                    compare_value("pmem_address", expected.wb_address, pmem_address);
                    compare_value("pmem_wdata", expected.wb_line, pmem_wdata);
                end
            end
            if (pmem_read && pmem_resp) begin
                saw_read   = 1'b1;
                since_resp = 0;
                if (expected.hit) begin
                    report_failure("a fill on a request that should hit");
                end else if (expected.writeback && !saw_write) begin
                    report_failure("the fill came before the write-back of a dirty victim");
                end
                compare_value("pmem_address", expected.fill_address, pmem_address);
            end
            if (mem_resp) begin
                compare_value("mem_rdata", expected.rdata, mem_rdata);
                if (expected.hit && (cycles != 2 || saw_read || saw_write)) begin
                    report_failure("a hit was not answered two cycles after sampling");
                end
                if (!expected.hit && (!saw_read || since_resp != 2)) begin
                    report_failure("a miss was not answered two cycles after its fill");
                end
                if (expected.writeback && !saw_write) begin
                    report_failure("a dirty victim was never written back");
                end
                busy = 1'b0;
            end
        end
    end

endmodule

/* test/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 5;
    localparam int max_delay    = 5;
    localparam int num_ops      = 4 + 2 + 10 + 5 + 4 + 300;   // all six tests together.

    logic             clk;
    logic             rst;
    logic             mem_read;
    logic             mem_write;
    cache_pkg::addr_t mem_address;
    cache_pkg::mask_t mem_byte_enable;
    cache_pkg::line_t mem_wdata;
    cache_pkg::line_t mem_rdata;
    logic             mem_resp;
    logic             pmem_read;
    logic             pmem_write;
    cache_pkg::addr_t pmem_address;
    cache_pkg::line_t pmem_wdata;
    cache_pkg::line_t pmem_rdata;
    logic             pmem_resp;

    cache_pkg::line_t memory [128];               // line-wide memory behind the cache.
    logic [31:0]      stim_seed;
    logic [31:0]      delay_seed;

    cache DUT (.*);

    cache_checker u_checker (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic cache_pkg::addr_t make_address(input int tag, input int index,
                                                      input int offset);
        return {20'b0, 3'(tag), 4'(index), 5'(offset)};
    endfunction

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // *************************************************************************
    // memory model, answering each transfer after 2 to 5 cycles
    // *************************************************************************
    initial begin
        int delay;
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        delay_seed = 42;
        for (int i = 0; i < 128; i++) begin
            memory[i] = u_checker.line_pattern({20'b0, 7'(i), 5'b0});
        end
        forever begin
            @(negedge clk);
            pmem_resp = 1'b0;
            if (!rst && (pmem_read || pmem_write)) begin
                delay_seed = lcg_next(delay_seed);
                delay      = 2 + int'(delay_seed[31:30]);
                repeat (delay) @(negedge clk);
                if (pmem_write) begin
                    memory[pmem_address[11:5]] = pmem_wdata;
                end else begin
                    pmem_rdata = memory[pmem_address[11:5]];
                end
                pmem_resp = 1'b1;
            end
        end
    end

    initial begin
        #((reset_cycles + num_ops * (2 * max_delay + 8)) * clk_period);
        $display("run timed out before all requests were answered");
        $display("Simulation failed");
        $finish;
    end

    // *************************************************************************
    // stimulus
    // *************************************************************************
    task automatic issue(input logic write, input cache_pkg::addr_t address,
                         input cache_pkg::mask_t enables, input cache_pkg::line_t data);
        mem_read        = !write;
        mem_write       = write;
        mem_address     = address;
        mem_byte_enable = enables;
        mem_wdata       = data;
        @(negedge clk);
        while (!mem_resp) begin
            @(negedge clk);
        end
        @(negedge clk);                           // held through the edge that ends compare.
        mem_read  = 1'b0;
        mem_write = 1'b0;
    endtask

    task automatic read_line(input int tag, input int index);
        issue(1'b0, make_address(tag, index, 0), '0, '0);
    endtask

    task automatic random_request();
        cache_pkg::line_t data;
        cache_pkg::mask_t enables;
        logic [31:0]      r;
        for (int w = 0; w < 8; w++) begin
            stim_seed        = lcg_next(stim_seed);
            data[w*32 +: 32] = stim_seed;
        end
        stim_seed = lcg_next(stim_seed);
        enables   = stim_seed;
        stim_seed = lcg_next(stim_seed);
        r         = stim_seed;
        issue(r[31], make_address(int'(r[30:28]), int'(r[27:26]) * 4 + 1, int'(r[25:21])),
              enables, data);
    endtask

    initial begin
        rst             = 1'b1;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_address     = '0;
        mem_byte_enable = '0;
        mem_wdata       = '0;
        stim_seed       = 42;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        for (int s = 0; s < 4; s++) begin
            read_line(0, s);
        end
        u_checker.finish_test("cold reads");

        issue(1'b1, make_address(0, 0, 4), 32'h0000_f00f, {8{32'hdead_beef}});
        read_line(0, 0);
        u_checker.finish_test("write hit merge");

        // four ways of set 3 go dirty, the fifth tag has to evict one of them.
        for (int t = 0; t < 5; t++) begin
            issue(1'b1, make_address(t, 3, 0), 32'h0f0f_0f0f << t, {8{32'(t + 1) * 32'h0101_0101}});
        end
        for (int t = 0; t < 5; t++) begin
            read_line(t, 3);
        end
        u_checker.finish_test("dirty eviction");

        for (int t = 0; t < 5; t++) begin
            read_line(t, 7);
        end
        u_checker.finish_test("clean eviction");

        read_line(5, 9);
        read_line(5, 9);
        issue(1'b1, make_address(5, 9, 0), 32'hffff_0000, {8{32'h1234_5678}});
        read_line(6, 9);
        u_checker.finish_test("hit and miss timing");

        repeat (300) random_request();
        u_checker.finish_test("random mix");

        $display("tests passed: %0d, tests failed: %0d",
                 u_checker.tests_passed, u_checker.tests_failed);
        if (u_checker.tests_failed == 0 && u_checker.errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* files.f */
rtl/cache_pkg.sv
rtl/cache_data_sram.sv
rtl/cache_tag_sram.sv
rtl/cache_flag_array.sv
rtl/cache_datapath.sv
rtl/cache_control.sv
rtl/cache.sv
test/cache_checker.sv
test/cache_tb.sv
